//--- alu2.f
hdl/alu2_pkg.sv
hdl/alu2_op_decoder.sv
hdl/alu2_sequencer.sv
hdl/booth_multiplier.sv
hdl/iter_shifter.sv
hdl/alu2.sv
dv/alu2_checker.sv
dv/alu2_tb.sv

//--- dv/alu2_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alu2_checker
    import alu2_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  i_clear,
    input wire logic                  o_busy,
    input wire logic                  o_i_error,
    input wire logic                  o_valid,
    input wire logic [XLEN-1:0]       o_res,
    input wire logic [REG_ADDR_W-1:0] o_rd
);

    a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid |-> o_busy)
        else $error("o_valid high while o_busy is low");

    a_error_idle: assert property (@(posedge clk) disable iff (!rst_n)
        o_i_error |-> !o_busy)
        else $error("o_i_error high while o_busy is high");

    // Result held under back-pressure
    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_clear) |=> (o_valid && $stable(o_res) && $stable(o_rd)))
        else $error("result or tag changed before clear");

    a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && i_clear) |=> !o_busy)
        else $error("o_busy still high after clear");

endmodule

bind alu2 alu2_checker chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_clear   (i_clear),
    .o_busy    (o_busy),
    .o_i_error (o_i_error),
    .o_valid   (o_valid),
    .o_res     (o_res),
    .o_rd      (o_rd)
);

`default_nettype wire

//--- dv/alu2_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu2_tb
    import alu2_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int SHIFT_STEP   = 1;
    localparam int N_DIRECTED   = 18;
    localparam int N_RANDOM     = 20;
    localparam int ENTRY_BUDGET = XLEN + 3 + 8;

    typedef struct {
        string                 name;
        logic [3:0]            cmd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
        int                    clear_delay;
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    logic [XLEN-1:0]       i_arg0;
    logic [XLEN-1:0]       i_arg1;
    alu_cmd_e              i_cmd;
    logic [REG_ADDR_W-1:0] i_rd;
    logic                  i_clear;
    logic                  o_busy;
    logic                  o_i_error;
    logic [XLEN-1:0]       o_res;
    logic [REG_ADDR_W-1:0] o_rd;
    logic                  o_valid;

    entry_t                table_q [N_DIRECTED];
    integer                seed;

    alu2 #(
        .SHIFT_STEP (SHIFT_STEP)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_arg0    (i_arg0),
        .i_arg1    (i_arg1),
        .i_cmd     (i_cmd),
        .i_rd      (i_rd),
        .i_clear   (i_clear),
        .o_busy    (o_busy),
        .o_i_error (o_i_error),
        .o_res     (o_res),
        .o_rd      (o_rd),
        .o_valid   (o_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_res(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR: %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR: %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_now($sformatf("ERROR: %s latency expected %0d actual %0d", name, exp, act));
        end
    endtask

    // RISC-V M and shift semantics
    function automatic logic [XLEN-1:0] model_result(input logic [3:0] cmd,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]  sa;
        logic [2*XLEN-1:0]  sb;
        logic [2*XLEN-1:0]  za;
        logic [2*XLEN-1:0]  zb;
        logic [2*XLEN-1:0]  prod;
        logic [SHAMT_W-1:0] sh;
        sa   = {{XLEN{a[XLEN-1]}}, a};
        sb   = {{XLEN{b[XLEN-1]}}, b};
        za   = {{XLEN{1'b0}}, a};
        zb   = {{XLEN{1'b0}}, b};
        sh   = b[SHAMT_W-1:0];
        prod = '0;
        model_result = '0;
        case (cmd)
            CMD_MUL:    prod = sa * sb;
            CMD_MULH:   prod = sa * sb;
            CMD_MULHSU: prod = sa * zb;
            CMD_MULHU:  prod = za * zb;
            default:    prod = '0;
        endcase
        case (cmd)
            CMD_MUL:    model_result = prod[XLEN-1:0];
            CMD_MULH,
            CMD_MULHSU,
            CMD_MULHU:  model_result = prod[2*XLEN-1:XLEN];
            CMD_SLL:    model_result = a << sh;
            CMD_SRL:    model_result = a >> sh;
            CMD_SRA:    model_result = $signed(a) >>> sh;
            default:    model_result = '0;
        endcase
    endfunction

    function automatic int model_latency(input logic [3:0] cmd, input logic [XLEN-1:0] b);
        if (cmd inside {CMD_SLL, CMD_SRL, CMD_SRA}) begin
            return 3 + (int'(b[SHAMT_W-1:0]) + SHIFT_STEP - 1) / SHIFT_STEP;
        end
        return XLEN + 3;
    endfunction

    function automatic bit is_op(input logic [3:0] cmd);
        return (cmd >= 4'h1) && (cmd <= 4'h7);
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [3:0] cmd,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                             input logic [REG_ADDR_W-1:0] rd, input int clear_delay);
        table_q[idx].name        = name;
        table_q[idx].cmd         = cmd;
        table_q[idx].a           = a;
        table_q[idx].b           = b;
        table_q[idx].rd          = rd;
        table_q[idx].clear_delay = clear_delay;
    endtask

    task automatic fill_table();
        set_entry(0,  "mul_small",      CMD_MUL,    32'd7,        32'd6,        5'd1,  0);
        set_entry(1,  "mul_neg_neg",    CMD_MUL,    32'hFFFFFFFD, 32'hFFFFFFFB, 5'd2,  1);
        set_entry(2,  "mulh_min_min",   CMD_MULH,   32'h80000000, 32'h80000000, 5'd3,  0);
        set_entry(3,  "mulh_neg_pos",   CMD_MULH,   32'hFFFFFFFF, 32'h7FFFFFFF, 5'd4,  0);
        set_entry(4,  "mulhsu_neg_pos", CMD_MULHSU, 32'hFFFFFFFE, 32'h00000003, 5'd5,  0);
        set_entry(5,  "mulhsu_neg_big", CMD_MULHSU, 32'h80000000, 32'hFFFFFFFF, 5'd6,  0);
        set_entry(6,  "mulhu_all_ones", CMD_MULHU,  32'hFFFFFFFF, 32'hFFFFFFFF, 5'd7,  2);
        set_entry(7,  "unknown_f",      4'hF,       32'h0000ABCD, 32'h00001234, 5'd8,  0);
        set_entry(8,  "sll_0",          CMD_SLL,    32'h12345678, 32'd0,        5'd9,  0);
        set_entry(9,  "sll_1",          CMD_SLL,    32'h92345678, 32'd1,        5'd10, 0);
        set_entry(10, "srl_17",         CMD_SRL,    32'h87654321, 32'd17,       5'd11, 0);
        set_entry(11, "sra_31_neg",     CMD_SRA,    32'h80000000, 32'd31,       5'd12, 0);
        set_entry(12, "sra_17_neg",     CMD_SRA,    32'hF0F0F0F0, 32'd17,       5'd13, 1);
        set_entry(13, "sll_upper_bits", CMD_SLL,    32'h00000001, 32'hFFFFFFE3, 5'd14, 0);
        set_entry(14, "mul_hold",       CMD_MUL,    32'h00001234, 32'h00005678, 5'd31, 5);
        set_entry(15, "unknown_9",      4'h9,       32'h00000001, 32'h00000002, 5'd15, 0);
        set_entry(16, "srl_31_hold",    CMD_SRL,    32'hFFFFFFFF, 32'd31,       5'd0,  3);
        set_entry(17, "mulh_max_max",   CMD_MULH,   32'h7FFFFFFF, 32'h7FFFFFFF, 5'd16, 0);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic run_op(input entry_t e);
        logic [XLEN-1:0]       exp_res;
        int                    exp_lat;
        int                    cycles;
        exp_res = model_result(e.cmd, e.a, e.b);
        exp_lat = model_latency(e.cmd, e.b);
        cycles  = 0;
        i_cmd   = alu_cmd_e'(e.cmd);
        i_arg0  = e.a;
        i_arg1  = e.b;
        i_rd    = e.rd;
        @(negedge clk);
        i_cmd = CMD_NONE;
        check_flag({e.name, " busy"}, 1'b1, o_busy);
        while (!o_valid && cycles <= exp_lat + 4) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_valid) begin
            fail_now($sformatf("o_valid never rose for %s", e.name));
        end
        check_cycles(e.name, exp_lat, cycles);
        check_res(e.name, exp_res, o_res);
        check_rd(e.name, e.rd, o_rd);
        check_flag({e.name, " busy at valid"}, 1'b1, o_busy);
        repeat (e.clear_delay) begin
            @(negedge clk);
            check_flag({e.name, " valid held"}, 1'b1, o_valid);
            check_flag({e.name, " busy held"}, 1'b1, o_busy);
            check_res({e.name, " res held"}, exp_res, o_res);
            check_rd({e.name, " rd held"}, e.rd, o_rd);
        end
        i_clear = 1'b1;
        @(negedge clk);
        i_clear = 1'b0;
        check_flag({e.name, " busy after clear"}, 1'b0, o_busy);
        check_flag({e.name, " valid after clear"}, 1'b0, o_valid);
    endtask

    task automatic run_unknown(input entry_t e);
        i_cmd  = alu_cmd_e'(e.cmd);
        i_arg0 = e.a;
        i_arg1 = e.b;
        i_rd   = e.rd;
        #(CLK_PERIOD / 4);
        check_flag({e.name, " error"}, 1'b1, o_i_error);
        check_flag({e.name, " busy"}, 1'b0, o_busy);
        repeat (3) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            check_flag({e.name, " error held"}, 1'b1, o_i_error);
            check_flag({e.name, " busy held"}, 1'b0, o_busy);
            check_flag({e.name, " no valid"}, 1'b0, o_valid);
        end
        @(negedge clk);
        i_cmd = CMD_NONE;
        #(CLK_PERIOD / 4);
        check_flag({e.name, " error dropped"}, 1'b0, o_i_error);
        check_flag({e.name, " still no valid"}, 1'b0, o_valid);
        @(negedge clk);
    endtask

    initial begin
        entry_t e;
        int     r;
        seed    = 5;
        clk     = 1'b0;
        rst_n   = 1'b0;
        i_arg0  = '0;
        i_arg1  = '0;
        i_cmd   = CMD_NONE;
        i_rd    = '0;
        i_clear = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("reset busy", 1'b0, o_busy);
        check_flag("reset valid", 1'b0, o_valid);
        check_flag("reset error", 1'b0, o_i_error);
        check_res("reset res", '0, o_res);
        check_rd("reset rd", '0, o_rd);
        for (int i = 0; i < N_DIRECTED; i++) begin
            if (is_op(table_q[i].cmd)) begin
                run_op(table_q[i]);
            end else begin
                run_unknown(table_q[i]);
            end
        end
        // Random mix of all seven operations
        for (int i = 0; i < N_RANDOM; i++) begin
            r             = $random(seed);
            e.name        = $sformatf("random_%0d", i);
            e.cmd         = 4'($unsigned(r) % 7 + 1);
            e.a           = $random(seed);
            e.b           = $random(seed);
            e.rd          = REG_ADDR_W'($random(seed));
            e.clear_delay = $unsigned($random(seed)) % 2;
            run_op(e);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + 2 + (N_DIRECTED + N_RANDOM) * ENTRY_BUDGET) * CLK_PERIOD);
        fail_now("Timeout: the test sequence did not complete in time");
    end

endmodule

`default_nettype wire

//--- hdl/alu2.sv
`timescale 1ns/1ps
`default_nettype none

module alu2
    import alu2_pkg::*;
#(
    parameter int SHIFT_STEP = 1
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [XLEN-1:0]       i_arg0,
    input  wire logic [XLEN-1:0]       i_arg1,
    input  wire alu_cmd_e              i_cmd,
    input  wire logic [REG_ADDR_W-1:0] i_rd,
    input  wire logic                  i_clear,
    output logic                       o_busy,
    output logic                       o_i_error,
    output logic [XLEN-1:0]            o_res,
    output logic [REG_ADDR_W-1:0]      o_rd,
    output logic                       o_valid
);

    // Decoder outputs
    logic            known;
    logic            sel_mul;
    logic            sel_shift;
    logic            dec_signed_a;
    logic            dec_signed_b;
    logic            dec_shift_left;
    logic            dec_shift_arith;
    logic            take_high;

    // Unit controls and results
    logic            mul_start;
    logic            mul_signed_a;
    logic            mul_signed_b;
    logic            mul_done;
    product_u        product;
    logic            shift_start;
    logic            shift_left;
    logic            shift_arith;
    logic            shift_done;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    alu2_op_decoder u_decoder (
        .i_cmd          (i_cmd),
        .o_known        (known),
        .o_sel_mul      (sel_mul),
        .o_sel_shift    (sel_shift),
        .o_mul_signed_a (dec_signed_a),
        .o_mul_signed_b (dec_signed_b),
        .o_shift_left   (dec_shift_left),
        .o_shift_arith  (dec_shift_arith),
        .o_take_high    (take_high)
    );

    alu2_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_arg0         (i_arg0),
        .i_arg1         (i_arg1),
        .i_cmd          (i_cmd),
        .i_rd           (i_rd),
        .i_clear        (i_clear),
        .i_known        (known),
        .i_sel_mul      (sel_mul),
        .i_sel_shift    (sel_shift),
        .i_mul_signed_a (dec_signed_a),
        .i_mul_signed_b (dec_signed_b),
        .i_shift_left   (dec_shift_left),
        .i_shift_arith  (dec_shift_arith),
        .i_take_high    (take_high),
        .i_mul_done     (mul_done),
        .i_product      (product),
        .i_shift_done   (shift_done),
        .i_shift_res    (shift_res),
        .o_busy         (o_busy),
        .o_i_error      (o_i_error),
        .o_res          (o_res),
        .o_rd           (o_rd),
        .o_valid        (o_valid),
        .o_mul_start    (mul_start),
        .o_mul_signed_a (mul_signed_a),
        .o_mul_signed_b (mul_signed_b),
        .o_shift_start  (shift_start),
        .o_shift_left   (shift_left),
        .o_shift_arith  (shift_arith),
        .o_op_a         (op_a),
        .o_op_b         (op_b)
    );

    booth_multiplier u_mul (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (mul_start),
        .i_signed_a (mul_signed_a),
        .i_signed_b (mul_signed_b),
        .i_a        (op_a),
        .i_b        (op_b),
        .o_done     (mul_done),
        .o_product  (product)
    );

    iter_shifter #(
        .SHIFT_STEP (SHIFT_STEP)
    ) u_shift (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (shift_start),
        .i_data  (op_a),
        .i_shamt (op_b[SHAMT_W-1:0]),
        .i_left  (shift_left),
        .i_arith (shift_arith),
        .o_done  (shift_done),
        .o_data  (shift_res)
    );

endmodule

`default_nettype wire

//--- hdl/alu2_op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu2_op_decoder
    import alu2_pkg::*;
(
    input  wire alu_cmd_e i_cmd,
    output logic          o_known,
    output logic          o_sel_mul,
    output logic          o_sel_shift,
    output logic          o_mul_signed_a,
    output logic          o_mul_signed_b,
    output logic          o_shift_left,
    output logic          o_shift_arith,
    output logic          o_take_high
);

    always_comb begin
        o_known        = 1'b0;
        o_sel_mul      = 1'b0;
        o_sel_shift    = 1'b0;
        o_mul_signed_a = 1'b0;
        o_mul_signed_b = 1'b0;
        o_shift_left   = 1'b0;
        o_shift_arith  = 1'b0;
        o_take_high    = 1'b0;

        case (i_cmd)
            CMD_MUL: begin
                o_known        = 1'b1;
                o_sel_mul      = 1'b1;
                o_mul_signed_a = 1'b1;
                o_mul_signed_b = 1'b1;
            end
            CMD_MULH: begin
                o_known        = 1'b1;
                o_sel_mul      = 1'b1;
                o_mul_signed_a = 1'b1;
                o_mul_signed_b = 1'b1;
                o_take_high    = 1'b1;
            end
            CMD_MULHSU: begin
                o_known        = 1'b1;
                o_sel_mul      = 1'b1;
                o_mul_signed_a = 1'b1;
                o_take_high    = 1'b1;
            end
            CMD_MULHU: begin
                o_known        = 1'b1;
                o_sel_mul      = 1'b1;
                o_take_high    = 1'b1;
            end
            CMD_SLL: begin
                o_known        = 1'b1;
                o_sel_shift    = 1'b1;
                o_shift_left   = 1'b1;
            end
            CMD_SRL: begin
                o_known        = 1'b1;
                o_sel_shift    = 1'b1;
            end
            CMD_SRA: begin
                o_known        = 1'b1;
                o_sel_shift    = 1'b1;
                o_shift_arith  = 1'b1;
            end
            // NONE and unassigned codes fall through with nothing selected
            default: begin
                o_known        = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu2_pkg.sv
`default_nettype none

package alu2_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);

    // Encodings 8 to 15 are not assigned
    typedef enum logic [3:0] {
        CMD_NONE   = 4'h0,
        CMD_MUL    = 4'h1,
        CMD_MULH   = 4'h2,
        CMD_MULHSU = 4'h3,
        CMD_MULHU  = 4'h4,
        CMD_SLL    = 4'h5,
        CMD_SRL    = 4'h6,
        CMD_SRA    = 4'h7
    } alu_cmd_e;

    // Full product, built as one word and read back by halves
    typedef union packed {
        logic [2*XLEN-1:0] flat;
        struct packed {
            logic [XLEN-1:0] hi;
            logic [XLEN-1:0] lo;
        } half;
    } product_u;

endpackage

`default_nettype wire

//--- hdl/alu2_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module alu2_sequencer
    import alu2_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire logic [XLEN-1:0]       i_arg0,
    input  wire logic [XLEN-1:0]       i_arg1,
    input  wire alu_cmd_e              i_cmd,
    input  wire logic [REG_ADDR_W-1:0] i_rd,
    input  wire logic                  i_clear,

    input  wire logic                  i_known,
    input  wire logic                  i_sel_mul,
    input  wire logic                  i_sel_shift,
    input  wire logic                  i_mul_signed_a,
    input  wire logic                  i_mul_signed_b,
    input  wire logic                  i_shift_left,
    input  wire logic                  i_shift_arith,
    input  wire logic                  i_take_high,

    input  wire logic                  i_mul_done,
    input  wire product_u              i_product,
    input  wire logic                  i_shift_done,
    input  wire logic [XLEN-1:0]       i_shift_res,

    output logic                       o_busy,
    output logic                       o_i_error,
    output logic [XLEN-1:0]            o_res,
    output logic [REG_ADDR_W-1:0]      o_rd,
    output logic                       o_valid,

    output logic                       o_mul_start,
    output logic                       o_mul_signed_a,
    output logic                       o_mul_signed_b,
    output logic                       o_shift_start,
    output logic                       o_shift_left,
    output logic                       o_shift_arith,
    output logic [XLEN-1:0]            o_op_a,
    output logic [XLEN-1:0]            o_op_b
);

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        START = 2'b01,
        WAIT  = 2'b10,
        OUT   = 2'b11
    } state_e;

    state_e                state;
    state_e                state_nxt;

    logic                  sel_mul;
    logic                  sel_shift;
    logic                  take_high;
    logic                  accept;
    logic                  unit_done;
    logic [XLEN-1:0]       unit_res;

    assign accept    = (state == IDLE) && i_known;
    assign unit_done = (sel_mul & i_mul_done) | (sel_shift & i_shift_done);

    // Result of whichever unit ran
    always_comb begin
        if (sel_mul) begin
            unit_res = take_high ? i_product.half.hi : i_product.half.lo;
        end else begin
            unit_res = i_shift_res;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = START;
            START:   state_nxt = WAIT;
            WAIT:    if (unit_done) state_nxt = OUT;
            OUT:     if (i_clear) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            sel_mul        <= 1'b0;
            sel_shift      <= 1'b0;
            take_high      <= 1'b0;
            o_mul_signed_a <= 1'b0;
            o_mul_signed_b <= 1'b0;
            o_shift_left   <= 1'b0;
            o_shift_arith  <= 1'b0;
            o_rd           <= '0;
            o_res          <= '0;
        end else begin
            state <= state_nxt;

            if (accept) begin
                sel_mul        <= i_sel_mul;
                sel_shift      <= i_sel_shift;
                take_high      <= i_take_high;
                o_mul_signed_a <= i_mul_signed_a;
                o_mul_signed_b <= i_mul_signed_b;
                o_shift_left   <= i_shift_left;
                o_shift_arith  <= i_shift_arith;
                o_rd           <= i_rd;
            end

            // Latched on the done cycle, held through OUT
            if ((state == WAIT) && unit_done) begin
                o_res <= unit_res;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_op_a <= i_arg0;
            o_op_b <= i_arg1;
        end
    end

    assign o_busy        = (state != IDLE);
    assign o_valid       = (state == OUT);
    assign o_i_error     = (state == IDLE) && !i_known && (i_cmd != CMD_NONE);
    assign o_mul_start   = (state == START) && sel_mul;
    assign o_shift_start = (state == START) && sel_shift;

endmodule

`default_nettype wire

//--- hdl/booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module booth_multiplier
    import alu2_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            i_start,
    input  wire logic            i_signed_a,
    input  wire logic            i_signed_b,
    input  wire logic [XLEN-1:0] i_a,
    input  wire logic [XLEN-1:0] i_b,
    output logic                 o_done,
    output product_u             o_product
);

    localparam int               CNT_W    = $clog2(XLEN) + 1;
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(XLEN - 1);
    localparam logic [CNT_W-1:0] ALL_BITS = CNT_W'(XLEN);

    logic                        busy;
    logic [CNT_W-1:0]            cnt;
    logic                        iterate;
    logic [2*XLEN-1:0]           mcand;
    logic [XLEN-1:0]             mplier;
    logic [2*XLEN-1:0]           partial;
    product_u                    acc;

    assign iterate = busy && (cnt != ALL_BITS);

    // MSB of a signed multiplier weighs -2^(XLEN-1)
    always_comb begin
        partial = '0;
        if (mplier[0]) begin
            if (i_signed_b && (cnt == LAST_BIT)) begin
                partial = -mcand;
            end else begin
                partial = mcand;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                if (cnt == ALL_BITS) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // One partial product per cycle
    always_ff @(posedge clk) begin
        if (i_start) begin
            if (i_signed_a) begin
                mcand <= {{XLEN{i_a[XLEN-1]}}, i_a};
            end else begin
                mcand <= {{XLEN{1'b0}}, i_a};
            end
            mplier   <= i_b;
            acc.flat <= '0;
        end else if (iterate) begin
            acc.flat <= acc.flat + partial;
            mcand    <= mcand << 1;
            mplier   <= mplier >> 1;
        end
    end

    assign o_product = acc;

endmodule

`default_nettype wire

//--- hdl/iter_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module iter_shifter
    import alu2_pkg::*;
#(
    parameter int SHIFT_STEP = 1
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               i_start,
    input  wire logic [XLEN-1:0]    i_data,
    input  wire logic [SHAMT_W-1:0] i_shamt,
    input  wire logic               i_left,
    input  wire logic               i_arith,
    output logic                    o_done,
    output logic [XLEN-1:0]         o_data
);

    logic                busy;
    logic [SHAMT_W-1:0]  remain;
    logic [SHAMT_W-1:0]  step;
    logic [XLEN-1:0]     data;
    logic [XLEN-1:0]     data_nxt;
    logic                fill;

    // Sign bit stays put during a right shift, so it can feed the fill
    assign fill = i_arith & data[XLEN-1];
    assign step = (remain > SHAMT_W'(SHIFT_STEP)) ? SHAMT_W'(SHIFT_STEP) : remain;

    // Chain of single-bit stages, only the first remain of them active
    always_comb begin
        data_nxt = data;
        for (int k = 0; k < SHIFT_STEP; k++) begin
            if (SHAMT_W'(k) < remain) begin
                if (i_left) begin
                    data_nxt = {data_nxt[XLEN-2:0], 1'b0};
                end else begin
                    data_nxt = {fill, data_nxt[XLEN-1:1]};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            remain <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy   <= 1'b1;
                remain <= i_shamt;
            end else if (busy) begin
                if (remain == '0) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    remain <= remain - step;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            data <= i_data;
        end else if (busy && (remain != '0)) begin
            data <= data_nxt;
        end
    end

    assign o_data = data;

endmodule

`default_nettype wire
